// ==== alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
    aluCtrlIf.aluSide ctrl,
    output logic [execPkg::DATA_WIDTH-1:0] result,
    output logic ofl,
    output logic cout,
    output logic ltZero,
    output logic zero
);
    import execPkg::*;

    logic [DATA_WIDTH-1:0] inA;
    logic [DATA_WIDTH-1:0] inB;
    logic [DATA_WIDTH-1:0] sum;
    logic [DATA_WIDTH-1:0] shOut;
    logic [4:0] carry;
    logic signedOfl;

    assign inA = ctrl.invA ? ~ctrl.a : ctrl.a;
    assign inB = ctrl.invB ? ~ctrl.b : ctrl.b;

    shifter u_shifter (
        .in(inA),
        .cnt(inB[3:0]),
        .op(ctrl.aluOp[1:0]),
        .out(shOut)
    );

    // Carry ripples between the four lookahead slices
    assign carry[0] = ctrl.cin;

    for (genvar n = 0; n < 4; n++) begin : gSlice
        cla4 u_cla4 (
            .a(inA[4*n +: 4]),
            .b(inB[4*n +: 4]),
            .cin(carry[n]),
            .sum(sum[4*n +: 4]),
            .cout(carry[n+1])
        );
    end

    assign cout = carry[4];

    always_comb begin
        case (ctrl.aluOp)
            opAdd, opSub: result = sum;
            opXor: result = inA ^ inB;
            opAnd: result = inA & inB;
            default: result = shOut;
        endcase
    end

    // Both inputs agree in sign but the sum does not
    assign signedOfl = (inA[DATA_WIDTH-1] & inB[DATA_WIDTH-1] & ~sum[DATA_WIDTH-1])
                     | (~inA[DATA_WIDTH-1] & ~inB[DATA_WIDTH-1] & sum[DATA_WIDTH-1]);

    assign ofl = ctrl.sign ? signedOfl : carry[4];

    // Unsigned compare falls back to the borrow
    assign ltZero = ctrl.sign ? (sum[DATA_WIDTH-1] ^ signedOfl) : ~carry[4];

    assign zero = ~|result;

endmodule

`default_nettype wire

// ==== aluCtrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface aluCtrlIf;
    import execPkg::*;

    logic valid;
    aluOp_t aluOp;
    logic invA;
    logic invB;
    logic cin;
    logic sign;
    logic [DATA_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] b;
    logic [REG_IDX_WIDTH-1:0] dest;
    logic [2:0] setKind;
    logic advance;

    modport decodeSide (
        output valid, aluOp, invA, invB, cin, sign, a, b, dest, setKind,
        input  advance
    );

    modport aluSide (input aluOp, invA, invB, cin, sign, a, b);

    modport resultSide (
        input  valid, dest, setKind,
        output advance
    );

endinterface

`default_nettype wire

// ==== cla4.sv ====
`timescale 1ns/1ps
`default_nettype none

module cla4 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic cin,
    output logic [3:0] sum,
    output logic cout
);

    logic [3:0] g;
    logic [3:0] p;
    logic [4:0] c;

    assign g = a & b;
    assign p = a ^ b;

    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & c[0]);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c[0]);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & c[0]);
    assign c[4] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0])
                | (p[3] & p[2] & p[1] & p[0] & c[0]);

    assign sum = p ^ c[3:0];
    assign cout = c[4];

endmodule

`default_nettype wire

// ==== execPkg.sv ====
`default_nettype none

package execPkg;

    localparam int DATA_WIDTH = 16;
    localparam int REG_IDX_WIDTH = 3;
    localparam int RESULT_CREDITS = 4;
    localparam int CREDIT_WIDTH = $clog2(RESULT_CREDITS + 1);

    // Set-on-condition kinds
    localparam logic [2:0] SET_NONE = 3'd0;
    localparam logic [2:0] SET_SEQ = 3'd1;
    localparam logic [2:0] SET_SLT = 3'd2;
    localparam logic [2:0] SET_SLE = 3'd3;
    localparam logic [2:0] SET_SCO = 3'd4;

    typedef enum logic [4:0] {
        aluR   = 5'd0,
        shiftR = 5'd1,
        addi   = 5'd2,
        subi   = 5'd3,
        xori   = 5'd4,
        andni  = 5'd5,
        roli   = 5'd6,
        slli   = 5'd7,
        rori   = 5'd8,
        srli   = 5'd9,
        seq    = 5'd10,
        slt    = 5'd11,
        sle    = 5'd12,
        sco    = 5'd13
    } opcode_t;

    // Low two bits go straight to the shifter
    typedef enum logic [2:0] {
        opRol = 3'd0, opSll = 3'd1, opRor = 3'd2, opSrl = 3'd3,
        opAdd = 3'd4, opSub = 3'd5, opXor = 3'd6, opAnd = 3'd7
    } aluOp_t;

    typedef union packed {
        struct packed {
            opcode_t opcode;
            logic [REG_IDX_WIDTH-1:0] rs;
            logic [REG_IDX_WIDTH-1:0] rt;
            logic [REG_IDX_WIDTH-1:0] rd;
            logic [1:0] funct;
        } rFmt;
        struct packed {
            opcode_t opcode;
            logic [REG_IDX_WIDTH-1:0] rs;
            logic [REG_IDX_WIDTH-1:0] rd;
            logic [4:0] imm;
        } iFmt;
    } instrWord_t;

endpackage

`default_nettype wire

// ==== execUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  logic clk,
    input  logic reset,
    input  execPkg::instrWord_t instr,
    input  logic [execPkg::DATA_WIDTH-1:0] opA,
    input  logic [execPkg::DATA_WIDTH-1:0] opB,
    input  logic inValid,
    output logic inReady,
    input  logic creditReturn,
    output logic outValid,
    output logic [execPkg::REG_IDX_WIDTH-1:0] outDest,
    output logic [execPkg::DATA_WIDTH-1:0] outData
);
    import execPkg::*;

    logic [DATA_WIDTH-1:0] aluResult;
    logic aluCout;
    logic aluLtZero;
    logic aluZero;

    aluCtrlIf ctrlIf ();

    instrDecode u_decode (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .opA(opA),
        .opB(opB),
        .inValid(inValid),
        .inReady(inReady),
        .ctrl(ctrlIf.decodeSide)
    );

    // Overflow has no consumer in this slice
    alu u_alu (
        .ctrl(ctrlIf.aluSide),
        .result(aluResult),
        .ofl(),
        .cout(aluCout),
        .ltZero(aluLtZero),
        .zero(aluZero)
    );

    resultStage u_result (
        .clk(clk),
        .reset(reset),
        .ctrl(ctrlIf.resultSide),
        .result(aluResult),
        .cout(aluCout),
        .ltZero(aluLtZero),
        .zero(aluZero),
        .creditReturn(creditReturn),
        .outValid(outValid),
        .outDest(outDest),
        .outData(outData)
    );

endmodule

`default_nettype wire

// ==== execUnit_testdata.txt ====
// instr opA opB dest data, all hex
014C 1234 4321 3 5555
0151 0005 0003 4 FFFE
015A F0F0 0FF0 6 FF00
015F ABCD 00FF 7 AB00
115F 0010 0000 2 000F
1965 0008 0000 3 FFFD
219F 1234 0000 4 122B
29AF 00FF 0000 5 00F0
0944 8001 0004 1 0018
0949 0003 000F 2 8000
094E 1234 0008 3 3412
095B 8000 000F 6 0001
31E0 BEEF 0000 7 BEEF
3921 4001 0000 1 8002
414F 8001 0000 2 0003
4974 F000 0000 3 0F00
5150 1234 1234 4 0001
5154 1234 1235 5 0000
5958 7FFF 8000 6 0001
595C 8000 7FFF 7 0000
6144 0005 0005 1 0001
6148 FFFF 0001 2 0000
694C FFFF 0001 3 0001

// ==== instrDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
    input  logic clk,
    input  logic reset,
    input  execPkg::instrWord_t instr,
    input  logic [execPkg::DATA_WIDTH-1:0] opA,
    input  logic [execPkg::DATA_WIDTH-1:0] opB,
    input  logic inValid,
    output logic inReady,
    aluCtrlIf.decodeSide ctrl
);
    import execPkg::*;

    aluOp_t nextOp;
    logic nextInvA;
    logic nextInvB;
    logic nextCin;
    logic nextSign;
    logic isIFmt;
    logic accept;
    logic [DATA_WIDTH-1:0] sextImm;
    logic [DATA_WIDTH-1:0] zextImm;
    logic [DATA_WIDTH-1:0] nextB;
    logic [REG_IDX_WIDTH-1:0] nextDest;
    logic [2:0] nextSetKind;

    assign sextImm = {{(DATA_WIDTH-5){instr.iFmt.imm[4]}}, instr.iFmt.imm};
    assign zextImm = {{(DATA_WIDTH-5){1'b0}}, instr.iFmt.imm};

    // Free slot, or the held item leaves this cycle
    assign inReady = ~ctrl.valid | ctrl.advance;
    assign accept = inValid & inReady;

    always_comb begin
        nextOp = opAdd;
        nextInvA = 1'b0;
        nextInvB = 1'b0;
        nextCin = 1'b0;
        nextSign = 1'b0;
        nextB = opB;
        nextSetKind = SET_NONE;
        isIFmt = 1'b1;
        case (instr.rFmt.opcode)
            aluR: begin
                isIFmt = 1'b0;
                nextOp = aluOp_t'({1'b1, instr.rFmt.funct});
                nextSign = (instr.rFmt.funct[1] == 1'b0);
                nextInvA = (instr.rFmt.funct == 2'd1);
                nextCin = (instr.rFmt.funct == 2'd1);
                nextInvB = (instr.rFmt.funct == 2'd3);
            end
            shiftR: begin
                isIFmt = 1'b0;
                nextOp = aluOp_t'({1'b0, instr.rFmt.funct});
            end
            addi: begin
                nextSign = 1'b1;
                nextB = sextImm;
            end
            // imm minus rs
            subi: begin
                nextOp = opSub;
                nextInvA = 1'b1;
                nextCin = 1'b1;
                nextSign = 1'b1;
                nextB = sextImm;
            end
            xori: begin
                nextOp = opXor;
                nextB = zextImm;
            end
            andni: begin
                nextOp = opAnd;
                nextInvB = 1'b1;
                nextB = zextImm;
            end
            roli, slli, rori, srli: begin
                nextOp = aluOp_t'(instr.rFmt.opcode - roli);
                nextB = zextImm;
            end
            // Compares work on rt minus rs
            seq, slt, sle: begin
                isIFmt = 1'b0;
                nextOp = opSub;
                nextInvA = 1'b1;
                nextCin = 1'b1;
                nextSign = 1'b1;
                nextSetKind = (instr.rFmt.opcode == seq) ? SET_SEQ :
                              (instr.rFmt.opcode == slt) ? SET_SLT : SET_SLE;
            end
            sco: begin
                isIFmt = 1'b0;
                nextSetKind = SET_SCO;
            end
            default: begin
                isIFmt = 1'b0;
            end
        endcase
        nextDest = isIFmt ? instr.iFmt.rd : instr.rFmt.rd;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.valid <= 1'b0;
        end else if (accept) begin
            ctrl.valid <= 1'b1;
        end else if (ctrl.advance) begin
            ctrl.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ctrl.aluOp <= nextOp;
            ctrl.invA <= nextInvA;
            ctrl.invB <= nextInvB;
            ctrl.cin <= nextCin;
            ctrl.sign <= nextSign;
            ctrl.a <= opA;
            ctrl.b <= nextB;
            ctrl.dest <= nextDest;
            ctrl.setKind <= nextSetKind;
        end
    end

endmodule

`default_nettype wire

// ==== resultStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module resultStage (
    input  logic clk,
    input  logic reset,
    aluCtrlIf.resultSide ctrl,
    input  logic [execPkg::DATA_WIDTH-1:0] result,
    input  logic cout,
    input  logic ltZero,
    input  logic zero,
    input  logic creditReturn,
    output logic outValid,
    output logic [execPkg::REG_IDX_WIDTH-1:0] outDest,
    output logic [execPkg::DATA_WIDTH-1:0] outData
);
    import execPkg::*;

    logic [CREDIT_WIDTH-1:0] credits;
    logic [DATA_WIDTH-1:0] wbValue;
    logic take;

    // Decode may hand over only while the consumer has room
    assign ctrl.advance = (credits != '0);
    assign take = ctrl.valid & ctrl.advance;

    always_comb begin
        case (ctrl.setKind)
            SET_SEQ: wbValue = {{(DATA_WIDTH-1){1'b0}}, zero};
            SET_SLT: wbValue = {{(DATA_WIDTH-1){1'b0}}, ltZero};
            SET_SLE: wbValue = {{(DATA_WIDTH-1){1'b0}}, ltZero | zero};
            SET_SCO: wbValue = {{(DATA_WIDTH-1){1'b0}}, cout};
            default: wbValue = result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            outValid <= 1'b0;
            credits <= CREDIT_WIDTH'(RESULT_CREDITS);
        end else begin
            outValid <= take;
            // One credit spent per item, one back per return pulse
            credits <= credits - CREDIT_WIDTH'(take) + CREDIT_WIDTH'(creditReturn);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            outDest <= ctrl.dest;
            outData <= wbValue;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbExecUnit

./obj_dir/VtbExecUnit > sim.log 2>&1
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module shifter (
    input  logic [15:0] in,
    input  logic [3:0] cnt,
    input  logic [1:0] op,
    output logic [15:0] out
);

    logic [15:0] stage [0:4];

    assign stage[0] = in;

    // Stage s moves by 2**s when cnt[s] is set
    for (genvar s = 0; s < 4; s++) begin : gStage
        logic [15:0] moved;

        always_comb begin
            case (op)
                2'b00: moved = (stage[s] << (2**s)) | (stage[s] >> (16 - 2**s));
                2'b01: moved = stage[s] << (2**s);
                2'b10: moved = (stage[s] >> (2**s)) | (stage[s] << (16 - 2**s));
                default: moved = stage[s] >> (2**s);
            endcase
        end

        assign stage[s+1] = cnt[s] ? moved : stage[s];
    end

    assign out = stage[4];

endmodule

`default_nettype wire

// ==== sources.f ====
execPkg.sv
aluCtrlIf.sv
shifter.sv
cla4.sv
alu.sv
instrDecode.sv
resultStage.sv
execUnit.sv
tbExecUnit.sv

// ==== tbExecUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbExecUnit;
    import execPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int CYCLES_PER_VECTOR = 40;
    // Consumer keeps its buffer full for a while so decode must stall
    localparam int HOLD_CYCLES = 12;

    logic clk;
    logic reset;
    instrWord_t instr;
    logic [DATA_WIDTH-1:0] opA;
    logic [DATA_WIDTH-1:0] opB;
    logic inValid;
    logic inReady;
    logic creditReturn;
    logic outValid;
    logic [REG_IDX_WIDTH-1:0] outDest;
    logic [DATA_WIDTH-1:0] outData;

    logic [15:0] vecInstr[$];
    logic [15:0] vecA[$];
    logic [15:0] vecB[$];
    logic [15:0] expDest[$];
    logic [15:0] expData[$];
    int numVec = 0;
    int outIdx = 0;
    bit running = 1'b0;
    bit loaded = 1'b0;
    bit sawStall = 1'b0;
    int resetErrors = 0;
    int dataErrors = 0;
    int creditErrors = 0;
    int orderErrors = 0;
    int stallErrors = 0;
    logic [15:0] lfsr;

    execUnit u_execUnit (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .opA(opA),
        .opB(opB),
        .inValid(inValid),
        .inReady(inReady),
        .creditReturn(creditReturn),
        .outValid(outValid),
        .outDest(outDest),
        .outData(outData)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic bit valueMatches(input string name, input logic [15:0] expected,
                                        input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("error: time %0t %s expected %h got %h", $time, name, expected, actual);
        end
        return actual === expected;
    endfunction

    task automatic loadVectors();
        int fd;
        int code;
        string header;
        logic [15:0] fInstr;
        logic [15:0] fA;
        logic [15:0] fB;
        logic [15:0] fDest;
        logic [15:0] fData;
        fd = $fopen("execUnit_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open execUnit_testdata.txt");
        end else begin
            // First line names the columns
            code = $fgets(header, fd);
            code = $fscanf(fd, "%h %h %h %h %h", fInstr, fA, fB, fDest, fData);
            while (code == 5) begin
                vecInstr.push_back(fInstr);
                vecA.push_back(fA);
                vecB.push_back(fB);
                expDest.push_back(fDest);
                expData.push_back(fData);
                code = $fscanf(fd, "%h %h %h %h %h", fInstr, fA, fB, fDest, fData);
            end
            $fclose(fd);
            numVec = vecInstr.size();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : mainFlow
        reset = 1'b1;
        loadVectors();
        if (numVec > 0) begin
            loaded = 1'b1;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;
        running = 1'b1;
        wait (outIdx >= numVec);
        repeat (8) @(posedge clk);
        assert (sawStall) else begin
            $display("inReady never went low while credits were withheld");
            stallErrors++;
        end
        $display({"Results %0d of %0d, reset errors %0d, data errors %0d, ",
                  "credit errors %0d, order errors %0d, stall errors %0d"},
                 outIdx, numVec, resetErrors, dataErrors, creditErrors, orderErrors,
                 stallErrors);
        if (numVec > 0 &&
            resetErrors + dataErrors + creditErrors + orderErrors + stallErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Reset state through one idle cycle after release
    initial begin : resetMonitor
        @(posedge clk);
        while (!running) begin
            @(negedge clk);
            if (!valueMatches("outValid", 16'd0, 16'(outValid))) resetErrors++;
            if (!valueMatches("inReady", 16'd1, 16'(inReady))) resetErrors++;
        end
    end

    initial begin : producer
        int idx;
        instr = '0;
        opA = '0;
        opB = '0;
        inValid = 1'b0;
        idx = 0;
        wait (running);
        while (idx < numVec) begin
            instr = vecInstr[idx];
            opA = vecA[idx];
            opB = vecB[idx];
            inValid = 1'b1;
            @(negedge clk);
            // Accepted at the coming edge
            if (inReady) idx++;
            else sawStall = 1'b1;
            @(posedge clk);
            #2;
        end
        inValid = 1'b0;
    end

    initial begin : consumer
        int cycles;
        int received;
        int returned;
        int tbCredits;
        logic countedReturn;
        creditReturn = 1'b0;
        lfsr = 16'd22923;
        cycles = 0;
        received = 0;
        returned = 0;
        tbCredits = RESULT_CREDITS;
        wait (running);
        forever begin
            @(posedge clk);
            #2;
            // The pulse driven last cycle was counted by the DUT at this edge
            countedReturn = creditReturn;
            creditReturn = 1'b0;
            if (cycles >= HOLD_CYCLES && received > returned) begin
                lfsr = lfsrStep(lfsr);
                if (lfsr[0]) begin
                    creditReturn = 1'b1;
                    returned++;
                end
            end
            cycles++;
            @(negedge clk);
            if (outValid) begin
                assert (tbCredits > 0) else begin
                    $display("outValid pulsed at time %0t with no credit left", $time);
                    creditErrors++;
                end
                tbCredits--;
                received++;
                assert (outIdx < numVec) else begin
                    $display("Extra result at time %0t after all %0d expected results",
                             $time, numVec);
                    orderErrors++;
                end
                if (outIdx < numVec) begin
                    if (!valueMatches("outDest", expDest[outIdx], 16'(outDest))) dataErrors++;
                    if (!valueMatches("outData", expData[outIdx], outData)) dataErrors++;
                end
                outIdx++;
            end
            if (countedReturn) tbCredits++;
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (RESET_CYCLES + CYCLES_PER_VECTOR * numVec) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived in time", outIdx, numVec);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
